/* build.f */
+incdir+src
src/sram_packet_pkg.sv
src/axil_pkg.sv
src/sram_port_if.sv
src/sram_macro_model.sv
src/control_logic.sv
src/axil_packet_host.sv
src/sram_test_top.sv
tests/tb_sram_test.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SRAM harness testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_sram_test \
    --Mdir obj_dir \
    -o tb_sram_test \
    -f build.f

./obj_dir/tb_sram_test | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"

/* tests/tb_sram_test.sv */
`default_nettype none
`timescale 1ns/1ps

`include "sram_test_settings.svh"

module tb_sram_test;

    import axil_pkg::*;
    import sram_packet_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int HS_TIMEOUT = 50;
    localparam int POLL_LIMIT = 40;

    logic                      clk_in;
    logic                      reset;
    logic [`AXIL_ADDR_W-1:0]   awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [`AXIL_DATA_W-1:0]   wdata;
    logic [`AXIL_DATA_W/8-1:0] wstrb;
    logic                      wvalid;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      bready;
    logic [`AXIL_ADDR_W-1:0]   araddr;
    logic                      arvalid;
    logic                      arready;
    logic [`AXIL_DATA_W-1:0]   rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
    logic                      rready;

    logic [31:0]             rng_state;
    logic [`SRAM_DATA_W-1:0] model_mem [2][`SRAM_DEPTH];
    int                      error_count;
    int                      check_count;
    int                      test_count;
    int                      failed_tests;

    sram_test_top i_sram_test_top (
        .clk_in  (clk_in),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Bytes with their mask bit set come from the new word
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] mask);
        logic [31:0] m;
        m = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                m[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return m;
    endfunction

    task automatic check_data(input string name, input logic [`SRAM_DATA_W-1:0] got,
                              input logic [`SRAM_DATA_W-1:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("** Error: %s: got 0x%08h, expected 0x%08h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_e got,
                              input axil_resp_e expected);
        check_count++;
        if (got !== expected) begin
            $display("** Error: %s: got 0x%0h, expected 0x%0h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        error_count++;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            failed_tests++;
            $display("Test %s: FAILED with %0d errors", name, error_count - errors_before);
        end
    endtask

    // Bus tasks are entered right after a falling edge and return after one
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output axil_resp_e resp);
        logic accepted;
        int   cycles;
        resp     = RESP_SLVERR;
        awaddr   = addr;
        wdata    = data;
        wstrb    = strb;
        awvalid  = 1'b1;
        wvalid   = 1'b1;
        accepted = 1'b0;
        cycles   = 0;
        // Sample the combinational awready once the inputs have settled
        while (!accepted && cycles < HS_TIMEOUT) begin
            #1;
            accepted = awready && wready;
            @(negedge clk_in);
            cycles++;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!accepted) begin
            report_timeout("the write address and data handshake");
            return;
        end
        bready = 1'b1;
        cycles = 0;
        while (!bvalid && cycles < HS_TIMEOUT) begin
            @(negedge clk_in);
            cycles++;
        end
        if (bvalid) begin
            resp = axil_resp_e'(bresp);
        end else begin
            report_timeout("the write response");
        end
        @(negedge clk_in);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output axil_resp_e resp);
        logic accepted;
        int   cycles;
        data     = '0;
        resp     = RESP_SLVERR;
        araddr   = addr;
        arvalid  = 1'b1;
        accepted = 1'b0;
        cycles   = 0;
        while (!accepted && cycles < HS_TIMEOUT) begin
            #1;
            accepted = arready;
            @(negedge clk_in);
            cycles++;
        end
        arvalid = 1'b0;
        if (!accepted) begin
            report_timeout("the read address handshake");
            return;
        end
        rready = 1'b1;
        cycles = 0;
        while (!rvalid && cycles < HS_TIMEOUT) begin
            @(negedge clk_in);
            cycles++;
        end
        if (rvalid) begin
            data = rdata;
            resp = axil_resp_e'(rresp);
        end else begin
            report_timeout("the read data");
        end
        @(negedge clk_in);
        rready = 1'b0;
    endtask

    task automatic load_packet(input sram_packet_t pkt);
        axil_resp_e resp;
        axil_write(REG_PACKET_LO, pkt[31:0], 4'hF, resp);
        check_resp("bresp", resp, RESP_OKAY);
        axil_write(REG_PACKET_HI, {8'h00, pkt[55:32]}, 4'hF, resp);
        check_resp("bresp", resp, RESP_OKAY);
    endtask

    task automatic wait_idle();
        axil_resp_e  resp;
        logic [31:0] status;
        int          polls;
        status = 32'h1;
        polls  = 0;
        while (status[0] && polls < POLL_LIMIT) begin
            axil_read(REG_STATUS, status, resp);
            check_resp("rresp", resp, RESP_OKAY);
            polls++;
        end
        if (status[0]) begin
            report_timeout("busy to clear");
        end
    endtask

    task automatic run_access(input sram_packet_t pkt, input read_port_e port,
                              output logic [31:0] word);
        axil_resp_e resp;
        load_packet(pkt);
        axil_write(REG_COMMAND, {30'd0, port, 1'b1}, 4'hF, resp);
        check_resp("bresp", resp, RESP_OKAY);
        wait_idle();
        axil_read(REG_READ_DATA, word, resp);
        check_resp("rresp", resp, RESP_OKAY);
    endtask

    task automatic sram_write(input logic bank, input logic [7:0] addr,
                              input logic [31:0] data, input logic [3:0] mask);
        sram_packet_t pkt;
        logic [31:0]  word;
        pkt          = '0;
        pkt.bank_sel = bank;
        pkt.csb0     = 1'b0;
        pkt.web0     = 1'b0;
        pkt.wmask0   = mask;
        pkt.addr0    = addr;
        pkt.din0     = data;
        pkt.csb1     = 1'b1;
        run_access(pkt, PORT_RW, word);
        model_mem[bank][addr] = merge_bytes(model_mem[bank][addr], data, mask);
    endtask

    function automatic sram_packet_t read_packet(input logic bank, input logic [7:0] addr,
                                                 input read_port_e port);
        sram_packet_t pkt;
        pkt          = '0;
        pkt.bank_sel = bank;
        pkt.web0     = 1'b1;
        pkt.csb0     = (port != PORT_RW);
        pkt.csb1     = (port != PORT_RO);
        pkt.addr0    = addr;
        pkt.addr1    = addr;
        return pkt;
    endfunction

    task automatic read_and_check(input logic bank, input logic [7:0] addr,
                                  input read_port_e port);
        logic [31:0] word;
        run_access(read_packet(bank, addr, port), port, word);
        check_data("read_data", word, model_mem[bank][addr]);
    endtask

    task automatic test_reset_state();
        int          errors_before;
        logic [31:0] data;
        axil_resp_e  resp;
        errors_before = error_count;
        check_data("bvalid", bvalid, 0);
        check_data("rvalid", rvalid, 0);
        check_data("awready", awready, 0);
        check_data("wready", wready, 0);
        check_data("arready", arready, 0);
        // A lone write channel is never taken
        awaddr  = REG_STATUS;
        awvalid = 1'b1;
        #1;
        check_data("awready", awready, 0);
        check_data("wready", wready, 0);
        @(negedge clk_in);
        awvalid = 1'b0;
        wvalid  = 1'b1;
        #1;
        check_data("awready", awready, 0);
        check_data("wready", wready, 0);
        @(negedge clk_in);
        wvalid = 1'b0;
        axil_read(REG_STATUS, data, resp);
        check_resp("rresp", resp, RESP_OKAY);
        check_data("status", data, 0);
        axil_read(REG_READ_DATA, data, resp);
        check_resp("rresp", resp, RESP_OKAY);
        check_data("read_data", data, 0);
        finish_test("reset state", errors_before);
    endtask

    task automatic test_write_read();
        int          errors_before;
        logic [7:0]  addrs [2][4];
        logic [31:0] r;
        errors_before = error_count;
        for (int bank = 0; bank < 2; bank++) begin
            for (int i = 0; i < 4; i++) begin
                r = next_random();
                addrs[bank][i] = r[7:0];
                sram_write(bank[0], addrs[bank][i], next_random(), 4'hF);
            end
        end
        for (int bank = 0; bank < 2; bank++) begin
            for (int i = 0; i < 4; i++) begin
                read_and_check(bank[0], addrs[bank][i], PORT_RW);
                read_and_check(bank[0], addrs[bank][i], PORT_RO);
            end
        end
        finish_test("write and read back", errors_before);
    endtask

    task automatic test_bank_isolation();
        int          errors_before;
        logic [31:0] r;
        logic [31:0] d0;
        errors_before = error_count;
        r  = next_random();
        d0 = next_random();
        sram_write(1'b0, r[7:0], d0, 4'hF);
        sram_write(1'b1, r[7:0], ~d0, 4'hF);
        read_and_check(1'b0, r[7:0], PORT_RW);
        read_and_check(1'b1, r[7:0], PORT_RW);
        read_and_check(1'b0, r[7:0], PORT_RO);
        finish_test("bank isolation", errors_before);
    endtask

    task automatic test_byte_mask();
        int          errors_before;
        logic [31:0] r;
        logic [3:0]  masks [3];
        errors_before = error_count;
        masks[0] = 4'b0101;
        masks[1] = 4'b1000;
        masks[2] = 4'b0110;
        for (int i = 0; i < 3; i++) begin
            r = next_random();
            sram_write(r[8], r[7:0], next_random(), 4'hF);
            sram_write(r[8], r[7:0], next_random(), masks[i]);
            read_and_check(r[8], r[7:0], PORT_RW);
            read_and_check(r[8], r[7:0], PORT_RO);
        end
        finish_test("byte mask", errors_before);
    endtask

    task automatic test_read_before_write();
        int           errors_before;
        logic [31:0]  r;
        logic [31:0]  new_word;
        logic [31:0]  word;
        sram_packet_t pkt;
        errors_before = error_count;
        r        = next_random();
        new_word = next_random();
        sram_write(1'b0, r[7:0], next_random(), 4'hF);
        // Port 0 write and port 1 read of one address in the same cycle
        pkt          = '0;
        pkt.bank_sel = 1'b0;
        pkt.csb0     = 1'b0;
        pkt.web0     = 1'b0;
        pkt.wmask0   = 4'hF;
        pkt.addr0    = r[7:0];
        pkt.din0     = new_word;
        pkt.csb1     = 1'b0;
        pkt.addr1    = r[7:0];
        run_access(pkt, PORT_RO, word);
        check_data("read_data", word, model_mem[0][r[7:0]]);
        model_mem[0][r[7:0]] = new_word;
        read_and_check(1'b0, r[7:0], PORT_RW);
        finish_test("read before write", errors_before);
    endtask

    task automatic test_error_responses();
        int          errors_before;
        logic [31:0] r;
        logic [31:0] data;
        axil_resp_e  resp;
        errors_before = error_count;
        axil_write(8'h14, 32'h1, 4'hF, resp);
        check_resp("bresp", resp, RESP_SLVERR);
        axil_read(8'h14, data, resp);
        check_resp("rresp", resp, RESP_SLVERR);
        check_data("rdata", data, 0);
        r = next_random();
        sram_write(1'b1, r[7:0], next_random(), 4'hF);
        load_packet(read_packet(1'b1, r[7:0], PORT_RW));
        axil_write(REG_COMMAND, 32'h1, 4'hF, resp);
        check_resp("bresp", resp, RESP_OKAY);
        // Second go lands while the first access is still in flight
        axil_write(REG_COMMAND, 32'h3, 4'hF, resp);
        check_resp("bresp", resp, RESP_SLVERR);
        wait_idle();
        axil_read(REG_READ_DATA, data, resp);
        check_resp("rresp", resp, RESP_OKAY);
        check_data("read_data", data, model_mem[1][r[7:0]]);
        finish_test("error responses", errors_before);
    endtask

    initial begin
        clk_in       = 1'b0;
        reset        = 1'b1;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        rng_state    = 32'h9a0cb95b;
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;

        repeat (5) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;
        @(negedge clk_in);

        test_reset_state();
        test_write_read();
        test_bank_isolation();
        test_byte_mask();
        test_read_before_write();
        test_error_responses();

        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/sram_test_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "sram_test_settings.svh"

module sram_test_top (
    input  logic                      clk_in,
    input  logic                      reset,
    // Write address
    input  logic [`AXIL_ADDR_W-1:0]   awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    // Write data
    input  logic [`AXIL_DATA_W-1:0]   wdata,
    input  logic [`AXIL_DATA_W/8-1:0] wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    // Write response
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    // Read address
    input  logic [`AXIL_ADDR_W-1:0]   araddr,
    input  logic                      arvalid,
    output logic                      arready,
    // Read data
    output logic [`AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready
);

    import sram_packet_pkg::*;

    sram_packet_t            packet;
    read_port_e              read_port;
    logic                    start;
    logic [`SRAM_DATA_W-1:0] read_data;
    logic                    read_valid;

    // Bus front end
    axil_packet_host i_axil_packet_host (
        .clk_in     (clk_in),
        .reset      (reset),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .packet     (packet),
        .read_port  (read_port),
        .start      (start),
        .read_data  (read_data),
        .read_valid (read_valid)
    );

    // Two SRAM banks and their steering
    control_logic i_control_logic (
        .clk_in     (clk_in),
        .reset      (reset),
        .packet     (packet),
        .read_port  (read_port),
        .start      (start),
        .read_data  (read_data),
        .read_valid (read_valid)
    );

endmodule

`default_nettype wire

/* src/axil_packet_host.sv */
`default_nettype none
`timescale 1ns/1ps

`include "sram_test_settings.svh"

module axil_packet_host (
    input  logic                          clk_in,
    input  logic                          reset,
    // Write address
    input  logic [`AXIL_ADDR_W-1:0]       awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    // Write data
    input  logic [`AXIL_DATA_W-1:0]       wdata,
    input  logic [`AXIL_DATA_W/8-1:0]     wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    // Write response
    output axil_pkg::axil_resp_e          bresp,
    output logic                          bvalid,
    input  logic                          bready,
    // Read address
    input  logic [`AXIL_ADDR_W-1:0]       araddr,
    input  logic                          arvalid,
    output logic                          arready,
    // Read data
    output logic [`AXIL_DATA_W-1:0]       rdata,
    output axil_pkg::axil_resp_e          rresp,
    output logic                          rvalid,
    input  logic                          rready,
    // Toward control logic
    output sram_packet_pkg::sram_packet_t packet,
    output sram_packet_pkg::read_port_e   read_port,
    output logic                          start,
    input  logic [`SRAM_DATA_W-1:0]       read_data,
    input  logic                          read_valid
);

    import axil_pkg::*;
    import sram_packet_pkg::*;

    localparam int STRB_W   = `AXIL_DATA_W / 8;
    localparam int PKT_HI_W = `SRAM_PACKET_W - `AXIL_DATA_W;

    host_state_e state;
    host_reg_e   wr_reg;
    host_reg_e   rd_reg;
    read_port_e  port_q;
    logic        busy;
    logic        rd_wait;
    logic        rd_err;
    logic [`AXIL_DATA_W-1:0] rd_word;
    logic [`AXIL_DATA_W-1:0] pkt_lo;
    logic [PKT_HI_W-1:0]     pkt_hi;
    logic [`SRAM_DATA_W-1:0] result;

    assign wr_reg = host_reg_e'(awaddr);
    assign rd_reg = host_reg_e'(araddr);

    // Address and data are taken in the same cycle, writes win over reads
    assign awready = (state == HOST_IDLE) && awvalid && wvalid;
    assign wready  = awready;
    assign arready = (state == HOST_IDLE) && arvalid && !(awvalid && wvalid);

    assign packet    = sram_packet_t'({pkt_hi, pkt_lo});
    assign read_port = port_q;

    // Packet registers with byte strobes
    always_ff @(posedge clk_in) begin
        if (awready && wr_reg == REG_PACKET_LO) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wstrb[i]) pkt_lo[8*i +: 8] <= wdata[8*i +: 8];
            end
        end
        if (awready && wr_reg == REG_PACKET_HI) begin
            for (int i = 0; i < PKT_HI_W / 8; i++) begin
                if (wstrb[i]) pkt_hi[8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // Read mux, result taken straight from the bus if it lands this cycle
    always_comb begin
        rd_err  = 1'b0;
        rd_word = '0;
        case (rd_reg)
            REG_PACKET_LO: rd_word = pkt_lo;
            REG_PACKET_HI: rd_word = {{(`AXIL_DATA_W-PKT_HI_W){1'b0}}, pkt_hi};
            REG_COMMAND:   rd_word = '0;
            REG_READ_DATA: rd_word = read_valid ? read_data : result;
            REG_STATUS:    rd_word = {{(`AXIL_DATA_W-1){1'b0}}, busy};
            default:       rd_err  = 1'b1;
        endcase
    end

    // Result read during an access waits for the word
    assign rd_wait = (rd_reg == REG_READ_DATA) && busy && !read_valid;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state  <= HOST_IDLE;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            bresp  <= RESP_OKAY;
            rresp  <= RESP_OKAY;
            start  <= 1'b0;
            busy   <= 1'b0;
            port_q <= PORT_RW;
            result <= '0;
        end else begin
            start <= 1'b0;
            if (read_valid) begin
                busy   <= 1'b0;
                result <= read_data;
            end
            case (state)
                HOST_IDLE: begin
                    if (awready) begin
                        bvalid <= 1'b1;
                        bresp  <= RESP_OKAY;
                        state  <= HOST_WRITE_RESP;
                        case (wr_reg)
                            REG_PACKET_LO, REG_PACKET_HI, REG_READ_DATA, REG_STATUS: ;
                            REG_COMMAND: begin
                                if (busy) begin
                                    bresp <= RESP_SLVERR;
                                end else begin
                                    port_q <= read_port_e'(wdata[1]);
                                    start  <= wdata[0];
                                    busy   <= wdata[0];
                                end
                            end
                            default: bresp <= RESP_SLVERR;
                        endcase
                    end else if (arready) begin
                        if (rd_wait) begin
                            state <= HOST_WAIT_ACCESS;
                        end else begin
                            rdata  <= rd_word;
                            rresp  <= rd_err ? RESP_SLVERR : RESP_OKAY;
                            rvalid <= 1'b1;
                            state  <= HOST_READ_RESP;
                        end
                    end
                end
                HOST_WAIT_ACCESS: begin
                    if (read_valid) begin
                        rdata  <= read_data;
                        rresp  <= RESP_OKAY;
                        rvalid <= 1'b1;
                        state  <= HOST_READ_RESP;
                    end
                end
                HOST_WRITE_RESP: begin
                    if (bready) begin
                        bvalid <= 1'b0;
                        state  <= HOST_IDLE;
                    end
                end
                HOST_READ_RESP: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        state  <= HOST_IDLE;
                    end
                end
                default: state <= HOST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/control_logic.sv */
`default_nettype none
`timescale 1ns/1ps

`include "sram_test_settings.svh"

module control_logic (
    input  logic                         clk_in,
    input  logic                         reset,
    input  sram_packet_pkg::sram_packet_t packet,
    input  sram_packet_pkg::read_port_e   read_port,
    input  logic                         start,
    output logic [`SRAM_DATA_W-1:0]      read_data,
    output logic                         read_valid
);

    import sram_packet_pkg::*;

    sram_packet_t pkt_q;
    read_port_e   port_q;
    read_port_e   port_d;
    logic         sel_d;
    logic         active;
    logic         pending;
    logic [1:0]   bank_en;
    logic [`SRAM_DATA_W-1:0] bank_word0;
    logic [`SRAM_DATA_W-1:0] bank_word1;

    sram_port_if bank0_if ();
    sram_port_if bank1_if ();

    sram_macro_model bank0 (
        .clk_in (clk_in),
        .port   (bank0_if.macro)
    );

    sram_macro_model bank1 (
        .clk_in (clk_in),
        .port   (bank1_if.macro)
    );

    // Packet and port choice, held until the next start
    always_ff @(posedge clk_in) begin
        if (start) begin
            pkt_q  <= packet;
            port_q <= read_port;
        end
    end

    // Enable window is the single cycle after start
    always_ff @(posedge clk_in) begin
        if (reset) begin
            active     <= 1'b0;
            pending    <= 1'b0;
            read_valid <= 1'b0;
        end else begin
            active     <= start;
            pending    <= active;
            read_valid <= pending;
        end
    end

    assign bank_en[0] = active & ~pkt_q.bank_sel;
    assign bank_en[1] = active &  pkt_q.bank_sel;

    // Bank 0 steering, chip selects forced high outside its window
    assign bank0_if.csb0   = pkt_q.csb0 | ~bank_en[0];
    assign bank0_if.csb1   = pkt_q.csb1 | ~bank_en[0];
    assign bank0_if.web0   = pkt_q.web0;
    assign bank0_if.wmask0 = pkt_q.wmask0;
    assign bank0_if.addr0  = pkt_q.addr0;
    assign bank0_if.din0   = pkt_q.din0;
    assign bank0_if.addr1  = pkt_q.addr1;

    // Bank 1 steering
    assign bank1_if.csb0   = pkt_q.csb0 | ~bank_en[1];
    assign bank1_if.csb1   = pkt_q.csb1 | ~bank_en[1];
    assign bank1_if.web0   = pkt_q.web0;
    assign bank1_if.wmask0 = pkt_q.wmask0;
    assign bank1_if.addr0  = pkt_q.addr0;
    assign bank1_if.din0   = pkt_q.din0;
    assign bank1_if.addr1  = pkt_q.addr1;

    // Bank and port follow the access into the macro read cycle
    always_ff @(posedge clk_in) begin
        if (active) begin
            sel_d  <= pkt_q.bank_sel;
            port_d <= port_q;
        end
    end

    assign bank_word0 = sel_d ? bank1_if.dout0 : bank0_if.dout0;
    assign bank_word1 = sel_d ? bank1_if.dout1 : bank0_if.dout1;

    // Word lands together with read_valid
    always_ff @(posedge clk_in) begin
        if (pending) begin
            read_data <= (port_d == PORT_RO) ? bank_word1 : bank_word0;
        end
    end

endmodule

`default_nettype wire

/* src/sram_macro_model.sv */
`default_nettype none
`timescale 1ns/1ps

`include "sram_test_settings.svh"

module sram_macro_model (
    input logic        clk_in,
    sram_port_if.macro port
);

    localparam int BYTE_W = `SRAM_DATA_W / `SRAM_WMASK_W;

    logic [`SRAM_DATA_W-1:0] mem [`SRAM_DEPTH];
    logic [`SRAM_DATA_W-1:0] dout0_q;
    logic [`SRAM_DATA_W-1:0] dout1_q;

    // Port 0, masked write or read
    // A write leaves dout0 at its last value
    always_ff @(posedge clk_in) begin
        if (!port.csb0) begin
            if (!port.web0) begin
                for (int b = 0; b < `SRAM_WMASK_W; b++) begin
                    if (port.wmask0[b]) begin
                        mem[port.addr0][b*BYTE_W +: BYTE_W] <= port.din0[b*BYTE_W +: BYTE_W];
                    end
                end
            end else begin
                dout0_q <= mem[port.addr0];
            end
        end
    end

    // Port 1 read, sees the array before any port 0 write on the same edge
    always_ff @(posedge clk_in) begin
        if (!port.csb1) begin
            dout1_q <= mem[port.addr1];
        end
    end

    assign port.dout0 = dout0_q;
    assign port.dout1 = dout1_q;

endmodule

`default_nettype wire

/* src/sram_port_if.sv */
`default_nettype none
`timescale 1ns/1ps

`include "sram_test_settings.svh"

interface sram_port_if;

    // Read/write port
    logic                       csb0;
    logic                       web0;
    logic [`SRAM_WMASK_W-1:0]   wmask0;
    logic [`SRAM_ADDR_W-1:0]    addr0;
    logic [`SRAM_DATA_W-1:0]    din0;
    logic [`SRAM_DATA_W-1:0]    dout0;

    // Read-only port
    logic                       csb1;
    logic [`SRAM_ADDR_W-1:0]    addr1;
    logic [`SRAM_DATA_W-1:0]    dout1;

    modport ctrl (
        output csb0, web0, wmask0, addr0, din0, csb1, addr1,
        input  dout0, dout1
    );

    modport macro (
        input  csb0, web0, wmask0, addr0, din0, csb1, addr1,
        output dout0, dout1
    );

endinterface

`default_nettype wire

/* src/axil_pkg.sv */
`default_nettype none

`include "sram_test_settings.svh"

package axil_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    // Register map, byte offsets
    typedef enum logic [`AXIL_ADDR_W-1:0] {
        REG_PACKET_LO = 8'h00,
        REG_PACKET_HI = 8'h04,
        REG_COMMAND   = 8'h08,
        REG_READ_DATA = 8'h0C,
        REG_STATUS    = 8'h10
    } host_reg_e;

    typedef enum logic [1:0] {
        HOST_IDLE,
        HOST_WRITE_RESP,
        HOST_READ_RESP,
        HOST_WAIT_ACCESS
    } host_state_e;

endpackage

`default_nettype wire

/* src/sram_packet_pkg.sv */
`default_nettype none

`include "sram_test_settings.svh"

package sram_packet_pkg;

    // One access to one bank, MSB first as the host writes it
    typedef struct packed {
        logic                       bank_sel;
        logic                       csb0;
        logic                       web0;
        logic [`SRAM_WMASK_W-1:0]   wmask0;
        logic [`SRAM_ADDR_W-1:0]    addr0;
        logic [`SRAM_DATA_W-1:0]    din0;
        logic                       csb1;
        logic [`SRAM_ADDR_W-1:0]    addr1;
    } sram_packet_t;

    // Which macro output goes back to the host
    typedef enum logic {
        PORT_RW = 1'b0,
        PORT_RO = 1'b1
    } read_port_e;

endpackage

`default_nettype wire

/* src/sram_test_settings.svh */
`ifndef SRAM_TEST_SETTINGS_SVH
`define SRAM_TEST_SETTINGS_SVH

// SRAM macro geometry
`define SRAM_DATA_W        32
`define SRAM_ADDR_W        8
`define SRAM_WMASK_W       4
`define SRAM_DEPTH         256

// Host packet, bank select down to port 1 address
`define SRAM_PACKET_W      56

// Edge sampling the enables to edge after which dout is valid
`define SRAM_READ_LATENCY  1

// AXI4-Lite register port
`define AXIL_ADDR_W        8
`define AXIL_DATA_W        32

`endif
